/* tb.f */
src/jesd_tx_pkg.sv
src/jesd_tx_lmfc.sv
src/jesd_tx_ctrl.sv
src/jesd_tx_lane.sv
src/jesd_tx.sv
bench/tb_jesd_tx.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the JESD204B transmit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_jesd_tx

output=$(./obj_dir/Vtb_jesd_tx)
echo "$output"

if echo "$output" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1

/* bench/tb_jesd_tx.sv */
// ****************************************
// Testbench for the JESD204B transmit link layer.
// Two lanes, 8 beats per multiframe, F = 4, 3 ILAS multiframes.
// A cycle model of the LMFC and link FSM feeds the assertions.
// ****************************************

`default_nettype none

module tb_jesd_tx;

  timeunit 1ns;
  timeprecision 100ps;

  import jesd_tx_pkg::*;

  localparam int NUM_LANES    = 2;
  localparam int BEATS        = 8;
  localparam int FRAME        = 4;
  localparam int ILAS_MFRAMES = 3;
  localparam int MF_OCTETS    = BEATS * BEAT_OCTETS;
  localparam int LANE_DW      = BEAT_OCTETS * 8;
  localparam int DATA_W       = LANE_DW * NUM_LANES;
  // Tests take about 200 cycles, the limit leaves a wide margin
  localparam int MAX_CYCLES   = 2000;

  logic                             clk = 1'b0;
  logic                             reset;
  logic                             i_sysref;
  logic                             i_sync;
  beat_count_t                      i_cfg_beats_per_multiframe;
  frame_log2_t                      i_cfg_octets_per_frame_log2;
  mframe_count_t                    i_cfg_mframes_per_ilas;
  logic [NUM_LANES-1:0]             i_cfg_lanes_disable;
  logic [DATA_W-1:0]                i_tx_data;
  logic                             o_tx_ready;
  logic [BEAT_OCTETS-1:0]           o_tx_sof;
  logic [BEAT_OCTETS-1:0]           o_tx_eof;
  logic [BEAT_OCTETS-1:0]           o_tx_somf;
  logic [BEAT_OCTETS-1:0]           o_tx_eomf;
  logic [DATA_W-1:0]                o_phy_data;
  logic [BEAT_OCTETS*NUM_LANES-1:0] o_phy_charisk;
  logic                             o_lmfc_edge;
  logic                             o_sysref_alignment_error;
  link_state_t                      o_status_state;

  int          errors = 0;
  int          tests_failed = 0;
  int          test_num = 0;
  int          cycles = 0;
  int          error_pulses;
  logic [31:0] lfsr_state = 32'hbbf7_7e2d;

  jesd_tx #(.NUM_LANES(NUM_LANES)) u_jesd_tx (.*);

  always #2 clk = ~clk;

  // ****************************************
  // Stimulus helpers
  // ****************************************

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [DATA_W-1:0] random_bits(int count);
    logic [DATA_W-1:0] bits;
    bits = '0;
    for (int b = 0; b < count; b++) begin
      bits = {bits[DATA_W-2:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return bits;
  endfunction

  always @(posedge clk) begin
    i_tx_data <= random_bits(DATA_W);
  end

  task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] expected);
    errors++;
    $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, expected);
  endtask

  task automatic report_failure(string what);
    errors++;
    $display("Error at %0t ns: %s", $time, what);
  endtask

  task automatic finish_test(string name, int errors_before);
    test_num++;
    if (errors == errors_before) begin
      $display("Test %0d, %s: ok", test_num, name);
    end else begin
      tests_failed++;
      $display("Test %0d, %s: failed, %0d errors", test_num, name, errors - errors_before);
    end
  endtask

  task automatic wait_for_state(link_state_t target, int limit);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (o_status_state != target && n < limit);
    if (o_status_state != target) begin
      report_failure($sformatf("link state never reached %s", target.name()));
    end
  endtask

  // Model beat of the cycle that has just ended
  task automatic wait_for_beat(int beat);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (m_beat != beat && n < 2 * BEATS);
    if (m_beat != beat) begin
      report_failure($sformatf("LMFC beat %0d never came", beat));
    end
  endtask

  task automatic wait_for_edge(int limit);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!o_lmfc_edge && n < limit);
    if (!o_lmfc_edge) begin
      report_failure("no LMFC edge after the first SYSREF rise");
    end
  endtask

  task automatic pulse_sysref();
    i_sysref <= 1'b1;
    repeat (2) @(posedge clk);
    i_sysref <= 1'b0;
    repeat (BEATS) @(posedge clk);
  endtask

  // ****************************************
  // Reference model
  // ****************************************

  logic        sysref_q;
  logic        sysref_rise;
  logic        m_last;
  logic        m_aligned;
  logic        m_error;
  int          m_beat;
  int          m_mframe;
  link_state_t m_state;

  assign sysref_rise = i_sysref && !sysref_q;
  assign m_last      = (m_beat == BEATS - 1);

  always @(posedge clk) begin
    if (reset) begin
      sysref_q  <= 1'b0;
      m_beat    <= 0;
      m_aligned <= 1'b0;
      m_error   <= 1'b0;
      m_state   <= ST_CGS;
      m_mframe  <= 0;
    end else begin
      sysref_q  <= i_sysref;
      // Only the first SYSREF rise restarts the multiframe
      m_beat    <= (sysref_rise && !m_aligned) ? 0 : (m_beat + 1) % BEATS;
      m_aligned <= m_aligned || sysref_rise;
      m_error   <= sysref_rise && m_aligned && !m_last;
      if (!i_sync) begin
        m_state <= ST_CGS;
      end else if (m_state == ST_CGS && m_aligned && m_last) begin
        m_state  <= ST_ILAS;
        m_mframe <= 0;
      end else if (m_state == ST_ILAS && m_last) begin
        if (m_mframe == ILAS_MFRAMES - 1) begin
          m_state <= ST_DATA;
        end else begin
          m_mframe <= m_mframe + 1;
        end
      end
    end
  end

  // Returns {charisk, octet}
  function automatic logic [8:0] expected_octet(link_state_t st, int mframe, int pos,
                                                logic [7:0] data);
    if (st == ST_DATA) return {1'b0, data};
    if (st != ST_ILAS) return {1'b1, K_K};
    if (pos == 0) return {1'b1, K_R};
    if (pos == MF_OCTETS - 1) return {1'b1, K_A};
    if (mframe == 1 && pos == 1) return {1'b1, K_Q};
    return {1'b0, 8'(pos)};
  endfunction

  logic [DATA_W-1:0]                exp_data;
  logic [BEAT_OCTETS*NUM_LANES-1:0] exp_charisk;
  logic [BEAT_OCTETS-1:0]           exp_sof;
  logic [BEAT_OCTETS-1:0]           exp_eof;
  logic [BEAT_OCTETS-1:0]           exp_somf;
  logic [BEAT_OCTETS-1:0]           exp_eomf;

  always @(posedge clk) begin
    logic [8:0] oct;
    if (reset) begin
      exp_data    <= '0;
      exp_charisk <= '0;
    end else begin
      for (int l = 0; l < NUM_LANES; l++) begin
        for (int o = 0; o < BEAT_OCTETS; o++) begin
          oct = expected_octet(m_state, m_mframe, m_beat * BEAT_OCTETS + o,
                               i_tx_data[l*LANE_DW + o*8 +: 8]);
          if (i_cfg_lanes_disable[l]) oct = '0;
          exp_data[l*LANE_DW + o*8 +: 8]  <= oct[7:0];
          exp_charisk[l*BEAT_OCTETS + o] <= oct[8];
        end
      end
    end
  end

  always_comb begin
    int pos;
    for (int o = 0; o < BEAT_OCTETS; o++) begin
      pos         = m_beat * BEAT_OCTETS + o;
      exp_sof[o]  = (pos % FRAME == 0);
      exp_eof[o]  = (pos % FRAME == FRAME - 1);
      exp_somf[o] = (pos == 0);
      exp_eomf[o] = (pos == MF_OCTETS - 1);
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      error_pulses <= 0;
    end else if (o_sysref_alignment_error) begin
      error_pulses <= error_pulses + 1;
    end
  end

  // ****************************************
  // Checks
  // ****************************************

  phy_data_matches: assert property (@(posedge clk) disable iff (reset)
    o_phy_data == exp_data)
    else report_mismatch("o_phy_data", $sampled(o_phy_data), $sampled(exp_data));

  phy_charisk_matches: assert property (@(posedge clk) disable iff (reset)
    o_phy_charisk == exp_charisk)
    else report_mismatch("o_phy_charisk", $sampled(o_phy_charisk), $sampled(exp_charisk));

  markers_match: assert property (@(posedge clk) disable iff (reset)
    {o_tx_sof, o_tx_eof, o_tx_somf, o_tx_eomf} == {exp_sof, exp_eof, exp_somf, exp_eomf})
    else report_mismatch("o_tx_sof/eof/somf/eomf",
                         $sampled({o_tx_sof, o_tx_eof, o_tx_somf, o_tx_eomf}),
                         $sampled({exp_sof, exp_eof, exp_somf, exp_eomf}));

  state_matches: assert property (@(posedge clk) disable iff (reset)
    o_status_state == m_state)
    else report_mismatch("o_status_state", $sampled(o_status_state), $sampled(m_state));

  ready_matches: assert property (@(posedge clk) disable iff (reset)
    o_tx_ready == (m_state == ST_DATA))
    else report_mismatch("o_tx_ready", $sampled(o_tx_ready), $sampled(m_state == ST_DATA));

  lmfc_edge_matches: assert property (@(posedge clk) disable iff (reset)
    o_lmfc_edge == (m_aligned && m_beat == 0))
    else report_mismatch("o_lmfc_edge", $sampled(o_lmfc_edge),
                         $sampled(m_aligned && m_beat == 0));

  align_error_matches: assert property (@(posedge clk) disable iff (reset)
    o_sysref_alignment_error == m_error)
    else report_mismatch("o_sysref_alignment_error", $sampled(o_sysref_alignment_error),
                         $sampled(m_error));

  first_rise_edge: assert property (@(posedge clk) disable iff (reset)
    (sysref_rise && !m_aligned) |=> o_lmfc_edge)
    else report_failure("no LMFC edge one cycle after the first SYSREF rise");

  edge_period: assert property (@(posedge clk) disable iff (reset)
    $past(o_lmfc_edge, BEATS) |-> o_lmfc_edge)
    else report_failure("LMFC edge did not repeat one multiframe later");

  error_single_cycle: assert property (@(posedge clk) disable iff (reset)
    o_sysref_alignment_error |=> !o_sysref_alignment_error)
    else report_failure("alignment error held for more than one cycle");

  sync_drop_ready: assert property (@(posedge clk) disable iff (reset)
    (!i_sync && o_tx_ready) |=> !o_tx_ready)
    else report_failure("o_tx_ready stayed high after SYNC~ dropped");

  // ****************************************
  // Timeout and test sequence
  // ****************************************

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    int start;
    int pulses;
    reset                       = 1'b1;
    i_sysref                    = 1'b0;
    i_sync                      = 1'b0;
    i_cfg_beats_per_multiframe  = 6'(BEATS - 1);
    i_cfg_octets_per_frame_log2 = 3'd2;
    i_cfg_mframes_per_ilas      = 4'(ILAS_MFRAMES);
    i_cfg_lanes_disable         = '0;
    i_tx_data                   = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    start = errors;
    repeat (12) @(posedge clk);
    finish_test("CGS after reset", start);

    start = errors;
    repeat (5) @(posedge clk);
    i_sysref <= 1'b1;
    wait_for_edge(2 * BEATS);
    i_sysref <= 1'b0;
    repeat (3 * BEATS) @(posedge clk);
    finish_test("LMFC alignment and markers", start);

    start  = errors;
    pulses = error_pulses;
    wait_for_beat(BEATS - 2);
    pulse_sysref();
    if (error_pulses != pulses) begin
      report_failure("alignment error raised by a SYSREF rise on the last beat");
    end
    wait_for_beat(2);
    pulse_sysref();
    if (error_pulses != pulses + 1) begin
      report_failure("no single alignment error for a SYSREF rise off the last beat");
    end
    repeat (2 * BEATS) @(posedge clk);
    finish_test("SYSREF alignment error", start);

    start = errors;
    i_sync <= 1'b1;
    wait_for_state(ST_ILAS, 2 * BEATS);
    wait_for_state(ST_DATA, ILAS_MFRAMES * BEATS + 2);
    finish_test("ILAS sequence", start);

    start = errors;
    repeat (2 * BEATS) @(posedge clk);
    i_cfg_lanes_disable <= 2'b10;
    repeat (2 * BEATS) @(posedge clk);
    finish_test("user data and lane disable", start);

    start = errors;
    i_sync <= 1'b0;
    wait_for_state(ST_CGS, 4);
    repeat (BEATS) @(posedge clk);
    finish_test("SYNC~ drop back to CGS", start);

    repeat (2) @(posedge clk);
    $display("Summary: %0d tests, %0d failed, %0d errors", test_num, tests_failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/jesd_tx.sv */
// ****************************************
// JESD204B 8B/10B transmit link layer, single clock domain.
// i_tx_data must be valid on every cycle o_tx_ready is high.
// Lane n uses bits [32n+31:32n] of the data buses.
// ****************************************

`default_nettype none

module jesd_tx #(
  parameter int NUM_LANES = 2
) (
  input  wire                                             clk,
  input  wire                                             reset,
  input  wire                                             i_sysref,
  input  wire                                             i_sync,
  input  wire jesd_tx_pkg::beat_count_t                   i_cfg_beats_per_multiframe,
  input  wire jesd_tx_pkg::frame_log2_t                   i_cfg_octets_per_frame_log2,
  input  wire jesd_tx_pkg::mframe_count_t                 i_cfg_mframes_per_ilas,
  input  wire [NUM_LANES-1:0]                             i_cfg_lanes_disable,
  input  wire [jesd_tx_pkg::BEAT_OCTETS*8*NUM_LANES-1:0]  i_tx_data,
  output wire                                             o_tx_ready,
  output wire [jesd_tx_pkg::BEAT_OCTETS-1:0]              o_tx_sof,
  output wire [jesd_tx_pkg::BEAT_OCTETS-1:0]              o_tx_eof,
  output wire [jesd_tx_pkg::BEAT_OCTETS-1:0]              o_tx_somf,
  output wire [jesd_tx_pkg::BEAT_OCTETS-1:0]              o_tx_eomf,
  output wire [jesd_tx_pkg::BEAT_OCTETS*8*NUM_LANES-1:0]  o_phy_data,
  output wire [jesd_tx_pkg::BEAT_OCTETS*NUM_LANES-1:0]    o_phy_charisk,
  output wire                                             o_lmfc_edge,
  output wire                                             o_sysref_alignment_error,
  output jesd_tx_pkg::link_state_t                        o_status_state
);

  import jesd_tx_pkg::*;

  localparam int LANE_DW = BEAT_OCTETS * 8;

  beat_count_t   beat_count;
  logic          lmfc_last;
  logic          lmfc_aligned;
  link_state_t   link_state;
  mframe_count_t ilas_mframe;

  jesd_tx_lmfc u_lmfc (
    .clk                         (clk),
    .reset                       (reset),
    .i_sysref                    (i_sysref),
    .i_cfg_beats_per_multiframe  (i_cfg_beats_per_multiframe),
    .i_cfg_octets_per_frame_log2 (i_cfg_octets_per_frame_log2),
    .o_beat_count                (beat_count),
    .o_lmfc_edge                 (o_lmfc_edge),
    .o_lmfc_last                 (lmfc_last),
    .o_lmfc_aligned              (lmfc_aligned),
    .o_sysref_alignment_error    (o_sysref_alignment_error),
    .o_sof                       (o_tx_sof),
    .o_eof                       (o_tx_eof),
    .o_somf                      (o_tx_somf),
    .o_eomf                      (o_tx_eomf)
  );

  jesd_tx_ctrl u_ctrl (
    .clk                    (clk),
    .reset                  (reset),
    .i_sync                 (i_sync),
    .i_lmfc_last            (lmfc_last),
    .i_lmfc_aligned         (lmfc_aligned),
    .i_cfg_mframes_per_ilas (i_cfg_mframes_per_ilas),
    .o_link_state           (link_state),
    .o_ilas_mframe          (ilas_mframe),
    .o_tx_ready             (o_tx_ready)
  );

  assign o_status_state = link_state;

  // One lane per slice of the data buses
  for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
    jesd_tx_lane u_lane (
      .clk            (clk),
      .reset          (reset),
      .i_lane_disable (i_cfg_lanes_disable[i]),
      .i_link_state   (link_state),
      .i_ilas_mframe  (ilas_mframe),
      .i_beat_count   (beat_count),
      .i_somf         (o_tx_somf),
      .i_eomf         (o_tx_eomf),
      .i_tx_data      (i_tx_data[i*LANE_DW +: LANE_DW]),
      .o_phy_data     (o_phy_data[i*LANE_DW +: LANE_DW]),
      .o_phy_charisk  (o_phy_charisk[i*BEAT_OCTETS +: BEAT_OCTETS])
    );
  end

endmodule

`default_nettype wire

/* src/jesd_tx_lane.sv */
// ****************************************
// Single lane octet generator with a registered output.
// ILAS multiframes carry only markers and position data,
// no link configuration words. No scrambling.
// ****************************************

`default_nettype none

module jesd_tx_lane (
  input  wire                                       clk,
  input  wire                                       reset,
  input  wire                                       i_lane_disable,
  input  wire jesd_tx_pkg::link_state_t             i_link_state,
  input  wire jesd_tx_pkg::mframe_count_t           i_ilas_mframe,
  input  wire jesd_tx_pkg::beat_count_t             i_beat_count,
  input  wire [jesd_tx_pkg::BEAT_OCTETS-1:0]        i_somf,
  input  wire [jesd_tx_pkg::BEAT_OCTETS-1:0]        i_eomf,
  input  wire [jesd_tx_pkg::BEAT_OCTETS*8-1:0]      i_tx_data,
  output logic [jesd_tx_pkg::BEAT_OCTETS*8-1:0]     o_phy_data,
  output logic [jesd_tx_pkg::BEAT_OCTETS-1:0]       o_phy_charisk
);

  import jesd_tx_pkg::*;

  logic [BEAT_OCTETS*8-1:0] next_data;
  logic [BEAT_OCTETS-1:0]   next_charisk;

  // ****************************************
  // Octet source select
  // ****************************************

  for (genvar i = 0; i < BEAT_OCTETS; i++) begin : gen_octet
    logic [7:0] octet_pos;
    octet_t     octet;
    logic       is_k;

    assign octet_pos = {i_beat_count, 2'b00} + 8'(i);

    always_comb begin
      octet = i_tx_data[i*8 +: 8];
      is_k  = 1'b0;

      if (i_lane_disable) begin
        octet = '0;
      end else begin
        case (i_link_state)
          ST_ILAS: begin
            if (i_somf[i]) begin
              octet = K_R;
              is_k  = 1'b1;
            end else if (i_eomf[i]) begin
              octet = K_A;
              is_k  = 1'b1;
            end else if (i_ilas_mframe == 4'd1 && octet_pos == 8'd1) begin
              // Second multiframe announces the configuration
              octet = K_Q;
              is_k  = 1'b1;
            end else begin
              octet = octet_pos;
            end
          end

          ST_DATA: begin
            octet = i_tx_data[i*8 +: 8];
          end

          default: begin
            octet = K_K;
            is_k  = 1'b1;
          end
        endcase
      end
    end

    assign next_data[i*8 +: 8] = octet;
    assign next_charisk[i]     = is_k;
  end

  // ****************************************
  // Output register
  // ****************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      o_phy_data    <= '0;
      o_phy_charisk <= '0;
    end else begin
      o_phy_data    <= next_data;
      o_phy_charisk <= next_charisk;
    end
  end

endmodule

`default_nettype wire

/* src/jesd_tx_ctrl.sv */
// ****************************************
// Link state machine, CGS then ILAS then DATA.
// ILAS starts on a multiframe boundary once the LMFC is aligned.
// i_cfg_mframes_per_ilas must be 1 to 15; zero is not supported.
// SYNC~ low in any state returns the link to CGS.
// ****************************************

`default_nettype none

module jesd_tx_ctrl (
  input  wire                              clk,
  input  wire                              reset,
  input  wire                              i_sync,
  input  wire                              i_lmfc_last,
  input  wire                              i_lmfc_aligned,
  input  wire jesd_tx_pkg::mframe_count_t  i_cfg_mframes_per_ilas,
  output jesd_tx_pkg::link_state_t         o_link_state,
  output jesd_tx_pkg::mframe_count_t       o_ilas_mframe,
  output logic                             o_tx_ready
);

  import jesd_tx_pkg::*;

  link_state_t   state;
  link_state_t   state_next;
  mframe_count_t mframe;
  mframe_count_t mframe_next;
  logic          final_mframe;

  assign final_mframe = (mframe == i_cfg_mframes_per_ilas - 4'd1);

  // ****************************************
  // Next state
  // ****************************************

  always_comb begin
    state_next  = state;
    mframe_next = mframe;

    if (!i_sync) begin
      state_next  = ST_CGS;
      mframe_next = '0;
    end else begin
      case (state)
        ST_CGS: begin
          // Receiver is synced; wait for the next multiframe boundary
          if (i_lmfc_aligned && i_lmfc_last) begin
            state_next  = ST_ILAS;
            mframe_next = '0;
          end
        end

        ST_ILAS: begin
          if (i_lmfc_last) begin
            if (final_mframe) begin
              state_next = ST_DATA;
            end else begin
              mframe_next = mframe + 1'b1;
            end
          end
        end

        ST_DATA: begin
          state_next = ST_DATA;
        end

        default: begin
          state_next  = ST_CGS;
          mframe_next = '0;
        end
      endcase
    end
  end

  // ****************************************
  // State registers
  // ****************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= ST_CGS;
      mframe <= '0;
    end else begin
      state  <= state_next;
      mframe <= mframe_next;
    end
  end

  assign o_link_state  = state;
  assign o_ilas_mframe = mframe;
  assign o_tx_ready    = (state == ST_DATA);

  // ILAS needs at least one multiframe to end on
  ilas_length_legal: assert property (
    @(posedge clk) disable iff (reset)
    i_cfg_mframes_per_ilas != 4'd0
  ) else $error("jesd_tx_ctrl: ILAS length of zero multiframes");

endmodule

`default_nettype wire

/* src/jesd_tx_lmfc.sv */
// ****************************************
// LMFC beat counter with one-shot SYSREF alignment.
// Only the first SYSREF rise moves the counter; later rises
// off the last beat only raise the alignment error flag.
// Frame size must be a power of two and divide the multiframe.
// ****************************************

`default_nettype none

module jesd_tx_lmfc (
  input  wire                                     clk,
  input  wire                                     reset,
  input  wire                                     i_sysref,
  input  wire jesd_tx_pkg::beat_count_t           i_cfg_beats_per_multiframe,
  input  wire jesd_tx_pkg::frame_log2_t           i_cfg_octets_per_frame_log2,
  output jesd_tx_pkg::beat_count_t                o_beat_count,
  output logic                                    o_lmfc_edge,
  output logic                                    o_lmfc_last,
  output logic                                    o_lmfc_aligned,
  output logic                                    o_sysref_alignment_error,
  output logic [jesd_tx_pkg::BEAT_OCTETS-1:0]     o_sof,
  output logic [jesd_tx_pkg::BEAT_OCTETS-1:0]     o_eof,
  output logic [jesd_tx_pkg::BEAT_OCTETS-1:0]     o_somf,
  output logic [jesd_tx_pkg::BEAT_OCTETS-1:0]     o_eomf
);

  import jesd_tx_pkg::*;

  logic        sysref_r;
  logic        sysref_rise;
  beat_count_t beat_count;
  logic        lmfc_last;
  logic        aligned;
  logic        align_error;
  logic [7:0]  frame_mask;

  assign sysref_rise = i_sysref & ~sysref_r;
  assign lmfc_last   = (beat_count == i_cfg_beats_per_multiframe);

  // ****************************************
  // Beat counter and SYSREF handling
  // ****************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      sysref_r    <= 1'b0;
      beat_count  <= '0;
      aligned     <= 1'b0;
      align_error <= 1'b0;
    end else begin
      sysref_r <= i_sysref;

      // First rise restarts the multiframe, then the counter runs freely
      if (sysref_rise && !aligned) begin
        beat_count <= '0;
      end else if (lmfc_last) begin
        beat_count <= '0;
      end else begin
        beat_count <= beat_count + 1'b1;
      end

      if (sysref_rise) begin
        aligned <= 1'b1;
      end

      // A rise in phase with the LMFC lands on the last beat
      align_error <= sysref_rise & aligned & ~lmfc_last;
    end
  end

  assign o_beat_count             = beat_count;
  assign o_lmfc_last              = lmfc_last;
  assign o_lmfc_aligned           = aligned;
  assign o_sysref_alignment_error = align_error;
  assign o_lmfc_edge              = aligned & (beat_count == '0);

  // ****************************************
  // Per-octet frame and multiframe markers
  // ****************************************

  assign frame_mask = (8'd1 << i_cfg_octets_per_frame_log2) - 8'd1;

  for (genvar i = 0; i < BEAT_OCTETS; i++) begin : gen_marker
    logic [7:0] octet_pos;

    // Octet position inside the multiframe
    assign octet_pos = {beat_count, 2'b00} + 8'(i);

    assign o_sof[i]  = ((octet_pos & frame_mask) == 8'd0);
    assign o_eof[i]  = ((octet_pos & frame_mask) == frame_mask);
    assign o_somf[i] = (octet_pos == 8'd0);
    assign o_eomf[i] = lmfc_last && (i == BEAT_OCTETS - 1);
  end

  // ****************************************
  // Checks
  // ****************************************

  // A frame never spans past the end of a multiframe
  frame_fits_multiframe: assert property (
    @(posedge clk) disable iff (reset)
    (9'd1 << i_cfg_octets_per_frame_log2) <=
      ({1'b0, i_cfg_beats_per_multiframe, 2'b00} + 9'd4)
  ) else $error("jesd_tx_lmfc: frame size exceeds the multiframe");

  // Frames hold at most 16 octets
  frame_size_legal: assert property (
    @(posedge clk) disable iff (reset)
    i_cfg_octets_per_frame_log2 <= 3'd4
  ) else $error("jesd_tx_lmfc: frame size above 16 octets");

endmodule

`default_nettype wire

/* src/jesd_tx_pkg.sv */
// ****************************************
// Shared widths, 8B/10B control characters and link states
// for the JESD204B transmit link layer.
// The datapath is fixed at four octets per lane per clock.
// ****************************************

`default_nettype none

package jesd_tx_pkg;

  // Octets per lane carried on each clock beat
  localparam int BEAT_OCTETS = 4;

  typedef logic [7:0] octet_t;

  // Beat index inside a multiframe, up to 64 beats
  typedef logic [5:0] beat_count_t;

  // log2 of octets per frame, legal range 0 to 4
  typedef logic [2:0] frame_log2_t;

  // Multiframe count for the ILAS phase
  typedef logic [3:0] mframe_count_t;

  typedef enum logic [1:0] {
    ST_CGS  = 2'd0,
    ST_ILAS = 2'd1,
    ST_DATA = 2'd2
  } link_state_t;

  // ****************************************
  // Control characters, sent with charisk set
  // ****************************************

  // K28.0, ILAS multiframe start
  localparam octet_t K_R = 8'h1C;
  // K28.3, lane alignment at multiframe end
  localparam octet_t K_A = 8'h7C;
  // K28.4, marks the configuration multiframe
  localparam octet_t K_Q = 8'h9C;
  // K28.5, code group synchronisation
  localparam octet_t K_K = 8'hBC;

endpackage

`default_nettype wire
